// ==== source/dot_matrix_pkg.sv ====
package dot_matrix_pkg;

    // panel geometry
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;

    // current scan row
    typedef logic [$clog2(MATRIX_ROWS)-1:0] row_idx_t;

    // one row of dots, bit per column
    typedef logic [MATRIX_COLS-1:0] col_bits_t;

    // row drivers, active low
    typedef logic [MATRIX_ROWS-1:0] row_lines_t;

    localparam row_lines_t ROWS_OFF = '1;  // all rows dark
    localparam col_bits_t COLS_OFF = '0;

endpackage

// ==== source/glyph_pkg.sv ====
package glyph_pkg;

    typedef logic [3:0] glyph_code_t;

    // codes at or above this are blank
    localparam int GLYPH_COUNT = 12;

    // row 0 first, bit 7 is the leftmost column
    localparam dot_matrix_pkg::col_bits_t GLYPH_TABLE
        [GLYPH_COUNT][dot_matrix_pkg::MATRIX_ROWS] = '{
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,   // small dot
          8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
          8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
          8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
          8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000},
        '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,   // full disc
          8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100},
        '{8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111,   // every dot on
          8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111},
        '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
          8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011},
        '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
          8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011},
        '{8'b0000_0000, 8'b0011_1000, 8'b0100_0100, 8'b0101_1010,
          8'b0100_1010, 8'b0011_0010, 8'b1100_0100, 8'b0011_1000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0110_0000, 8'b1111_1100,
          8'b0011_1111, 8'b0011_1110, 8'b0001_1100, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0111_1110, 8'b0111_1110, 8'b0010_0100, 8'b0000_0000},
        '{8'b1110_0000, 8'b0110_0000, 8'b1110_0000, 8'b0011_0000,
          8'b0011_0001, 8'b0011_0011, 8'b0011_1110, 8'b0001_1100}
    };

    // dots of one glyph row, zero for blank codes
    function automatic dot_matrix_pkg::col_bits_t glyph_row(
        input glyph_code_t              code,
        input dot_matrix_pkg::row_idx_t r
    );
        dot_matrix_pkg::col_bits_t bits;
        if (int'(code) >= GLYPH_COUNT)
        begin
            bits = '0;
        end
        else
        begin
            bits = GLYPH_TABLE[code][r];
        end
        return bits;
    endfunction

endpackage

// ==== source/glyph_select.sv ====
`timescale 1ns/1ns

module glyph_select (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st,
    input  glyph_pkg::glyph_code_t num,
    output glyph_pkg::glyph_code_t glyph,
    output logic                  blank
);

    import glyph_pkg::*;

    logic code_blank;

    assign code_blank = (int'(num) >= GLYPH_COUNT);  // codes past the table

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            glyph <= '0;
            blank <= 1'b1;
        end
        else if (!st)
        begin
            glyph <= '0;  // display off
            blank <= 1'b1;
        end
        else
        begin
            glyph <= num;
            blank <= code_blank;
        end
    end

    // frame_driver relies on this to index the table safely
    a_blank_code: assert property (
        @(posedge clk) disable iff (rst)
        !blank |-> (int'(glyph) < GLYPH_COUNT)
    ) else $error("glyph %0d passed as visible", glyph);

endmodule

// ==== source/row_scan.sv ====
`timescale 1ns/1ns

module row_scan #(
    parameter int SCAN_DIV = 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     st,
    output dot_matrix_pkg::row_idx_t row_idx
);

    import dot_matrix_pkg::*;

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_W'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            row_idx <= '0;
        end
        else if (!st)
        begin
            div_cnt <= '0;  // restart scan from row 0
            row_idx <= '0;
        end
        else if (div_wrap)
        begin
            div_cnt <= '0;
            if (row_idx == row_idx_t'(MATRIX_ROWS - 1))
                row_idx <= '0;
            else
                row_idx <= row_idx + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // each row must hold for the full prescale period
    a_row_pace: assert property (
        @(posedge clk) disable iff (rst)
        $changed(row_idx) |-> $past(div_wrap || !st)
    ) else $error("row_idx moved mid period");

endmodule

// ==== source/frame_driver.sv ====
`timescale 1ns/1ns

module frame_driver (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  logic                       temp,
    input  glyph_pkg::glyph_code_t     glyph,
    input  logic                       blank,
    input  dot_matrix_pkg::row_idx_t   row_idx,
    output dot_matrix_pkg::row_lines_t row,
    output dot_matrix_pkg::col_bits_t  colg,
    output dot_matrix_pkg::col_bits_t  colr
);

    import dot_matrix_pkg::*;
    import glyph_pkg::*;

    row_lines_t row_next;
    col_bits_t  dots;
    col_bits_t  red_dots;

    // one low line for the current row
    assign row_next = ~(row_lines_t'(1) << row_idx);

    always_comb
    begin
        if (blank)
            dots = COLS_OFF;
        else
            dots = glyph_row(glyph, row_idx);
    end

    assign red_dots = temp ? dots : COLS_OFF;  // green plus red gives amber

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= ROWS_OFF;
            colg <= COLS_OFF;
            colr <= COLS_OFF;
        end
        else if (!st)
        begin
            row  <= ROWS_OFF;
            colg <= COLS_OFF;
            colr <= COLS_OFF;
        end
        else
        begin
            row  <= row_next;
            colg <= dots;
            colr <= red_dots;
        end
    end

    // two rows lit at once would short the column drive
    a_single_row: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(~row)
    ) else $error("row lines %b select more than one row", row);

endmodule

// ==== source/matrix_display.sv ====
`timescale 1ns/1ns

module matrix_display #(
    parameter int SCAN_DIV = 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  logic                       temp,
    input  glyph_pkg::glyph_code_t     num,
    output dot_matrix_pkg::row_lines_t row,
    output dot_matrix_pkg::col_bits_t  colg,
    output dot_matrix_pkg::col_bits_t  colr
);

    import dot_matrix_pkg::*;
    import glyph_pkg::*;

    glyph_code_t glyph;
    logic        blank;
    row_idx_t    row_idx;

    glyph_select glyph_select_inst (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .num   (num),
        .glyph (glyph),
        .blank (blank)
    );

    row_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) row_scan_inst (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .row_idx (row_idx)
    );

    frame_driver frame_driver_inst (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .temp    (temp),
        .glyph   (glyph),
        .blank   (blank),
        .row_idx (row_idx),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release 1 ns after the last reset edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== bench/matrix_display_tb.sv ====
`timescale 1ns/1ns

module matrix_display_tb;

    import dot_matrix_pkg::*;
    import glyph_pkg::*;

    localparam int SCAN_DIV     = 2;
    localparam int FRAME_CYCLES = MATRIX_ROWS * SCAN_DIV;
    localparam int N_ENTRIES    = 24;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic [3:0] num;
        logic       temp;
        logic       st;
        logic [7:0] frames;
    } entry_t;

    // num, temp, st, frames; zero frames gives a short 4 cycle step
    localparam entry_t STIM [N_ENTRIES] = '{
        '{4'd0,  1'b0, 1'b0, 8'd0},  // dark right after reset
        '{4'd0,  1'b0, 1'b1, 8'd1},
        '{4'd1,  1'b1, 1'b1, 8'd1},
        '{4'd2,  1'b0, 1'b1, 8'd1},
        '{4'd3,  1'b1, 1'b1, 8'd1},
        '{4'd4,  1'b0, 1'b1, 8'd1},
        '{4'd5,  1'b1, 1'b1, 8'd1},
        '{4'd6,  1'b0, 1'b1, 8'd1},
        '{4'd7,  1'b1, 1'b1, 8'd1},
        '{4'd8,  1'b0, 1'b1, 8'd1},
        '{4'd9,  1'b1, 1'b1, 8'd1},
        '{4'd10, 1'b0, 1'b1, 8'd1},
        '{4'd11, 1'b1, 1'b1, 8'd2},
        '{4'd12, 1'b1, 1'b1, 8'd1},  // blank codes
        '{4'd13, 1'b0, 1'b1, 8'd1},
        '{4'd14, 1'b1, 1'b1, 8'd1},
        '{4'd15, 1'b1, 1'b1, 8'd1},
        '{4'd6,  1'b1, 1'b0, 8'd1},  // display off
        '{4'd6,  1'b1, 1'b1, 8'd1},  // scan restarts
        '{4'd9,  1'b0, 1'b1, 8'd0},  // mid frame code changes
        '{4'd3,  1'b1, 1'b1, 8'd0},
        '{4'd11, 1'b0, 1'b1, 8'd1},
        '{4'd4,  1'b1, 1'b1, 8'd1},
        '{4'd7,  1'b0, 1'b0, 8'd0}
    };

    logic        clk;
    logic        rst;
    logic        st;
    logic        temp;
    glyph_code_t num;
    row_lines_t  row;
    col_bits_t   colg;
    col_bits_t   colr;

    // expected state of the decode and scan stages
    glyph_code_t sel_code;
    logic        sel_blank;
    int          scan_pos;

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    clock_gen clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    matrix_display #(
        .SCAN_DIV (SCAN_DIV)
    ) matrix_display_inst (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    // row 0 in the top byte, bit 7 leftmost
    function automatic logic [63:0] glyph_pattern(input int code);
        case (code)
            0:       return 64'h0000_183C_3C18_0000;
            1:       return 64'h0000_387C_7C38_0000;
            2:       return 64'h0000_3C7E_7E3C_0000;
            3:       return 64'h003C_7E7E_7E7E_3C00;
            4:       return 64'h3C7E_FFFF_FFFF_7E3C;
            5:       return 64'hFFFF_FFFF_FFFF_FFFF;
            6:       return 64'hC3E3_F1E3_C7E7_F7FB;
            7:       return 64'h0001_81C3_83C7_E7F3;
            8:       return 64'h0038_445A_4A32_C438;
            9:       return 64'h0000_60FC_3F3E_1C00;
            10:      return 64'h0000_183C_7E7E_2400;
            11:      return 64'hE060_E030_3133_3E1C;
            default: return 64'h0;
        endcase
    endfunction

    function automatic col_bits_t glyph_dots(input int code, input int r);
        logic [63:0] pat;
        pat = glyph_pattern(code);
        return pat[63 - 8 * r -: 8];
    endfunction

    function automatic row_lines_t row_select(input int idx);
        row_lines_t lines;
        for (int i = 0; i < MATRIX_ROWS; i++)
            lines[i] = (i != idx);  // only the active row pulled low
        return lines;
    endfunction

    task automatic compare_outputs(
        input row_lines_t exp_row,
        input col_bits_t  exp_colg,
        input col_bits_t  exp_colr
    );
        check_count = check_count + 1;
        if (row !== exp_row)
        begin
            $display("[ERROR] %0t ns row expected %b got %b", $time, exp_row, row);
            error_count = error_count + 1;
        end
        if (colg !== exp_colg)
        begin
            $display("[ERROR] %0t ns colg expected %b got %b", $time, exp_colg, colg);
            error_count = error_count + 1;
        end
        if (colr !== exp_colr)
        begin
            $display("[ERROR] %0t ns colr expected %b got %b", $time, exp_colr, colr);
            error_count = error_count + 1;
        end
    endtask

    // one clock edge, outputs checked 1 ns later
    task automatic step_cycle();
        row_lines_t exp_row;
        col_bits_t  exp_colg;
        col_bits_t  exp_colr;
        int         idx;
        @(posedge clk);
        #1;
        idx = (scan_pos / SCAN_DIV) % MATRIX_ROWS;
        if (!st)
        begin
            exp_row  = '1;
            exp_colg = '0;
            exp_colr = '0;
            scan_pos = 0;
        end
        else
        begin
            exp_row = row_select(idx);
            if (sel_blank)
                exp_colg = '0;
            else
                exp_colg = glyph_dots(int'(sel_code), idx);
            exp_colr = temp ? exp_colg : '0;
            scan_pos = (scan_pos + 1) % FRAME_CYCLES;
        end
        compare_outputs(exp_row, exp_colg, exp_colr);
        if (!st)
        begin
            sel_code  = '0;
            sel_blank = 1'b1;
        end
        else
        begin
            sel_code  = num;
            sel_blank = 1'b0;  // codes past 11 have an empty pattern
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        int len;
        int errors_before;
        st          = 1'b0;
        temp        = 1'b0;
        num         = '0;
        sel_code    = '0;
        sel_blank   = 1'b1;
        scan_pos    = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = MARGIN;
        for (int e = 0; e < N_ENTRIES; e++)
            cycle_limit = cycle_limit + int'(STIM[e].frames) * FRAME_CYCLES + 4;

        while (rst)
        begin
            @(negedge clk);
            if (rst)
                compare_outputs('1, '0, '0);
        end
        step_cycle();  // first edge out of reset

        for (int e = 0; e < N_ENTRIES; e++)
        begin
            errors_before = error_count;
            num  = STIM[e].num;
            temp = STIM[e].temp;
            st   = STIM[e].st;
            len  = int'(STIM[e].frames) * FRAME_CYCLES + 4;
            repeat (len) step_cycle();
            $display("entry %0d num=%0d temp=%0b st=%0b cycles=%0d errors=%0d",
                     e, STIM[e].num, STIM[e].temp, STIM[e].st, len,
                     error_count - errors_before);
        end

        $display("entries=%0d checks=%0d errors=%0d", N_ENTRIES, check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
source/dot_matrix_pkg.sv
source/glyph_pkg.sv
source/glyph_select.sv
source/row_scan.sv
source/frame_driver.sv
source/matrix_display.sv
bench/clock_gen.sv
bench/matrix_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the matrix display testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module matrix_display_tb \
    -f tb.f \
    -Mdir obj_dir \
    -o matrix_display_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/matrix_display_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
